// File: hdl/audio_dma_pkg.sv
/* Shared widths, TLP constants and stream structs for the audio DMA uplink.
   Only 3DW memory writes with 32-bit addresses are covered. */
`default_nettype none

package audio_dma_pkg;

  localparam int BEAT_W           = 128;               // stream data width
  localparam int SAMPLE_W         = 16;
  localparam int SAMPLES_PER_BEAT = BEAT_W / SAMPLE_W; // 8 samples per beat

  typedef logic [BEAT_W-1:0]   beat_t;
  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [31:0]         dma_addr_t;
  typedef logic [7:0]          bus_num_t;
  typedef logic [4:0]          dev_num_t;

  // command stream from the host side
  typedef struct packed {
    logic  valid;
    beat_t data;
    logic  last;
  } in_beat_t;

  // TLP stream towards the core, valid travels beside it
  typedef struct packed {
    beat_t data;
    logic  last;
  } out_beat_t;

  // fmt 010, type 00000
  localparam logic [7:0]  MWR32_FMT_TYPE   = 8'h40;
  localparam logic [11:0] CMD_ADDR_OFFSET  = 12'h110; // next DMA buffer address
  localparam logic [11:0] CMD_CLEAR_OFFSET = 12'h130; // drop config and flush
  localparam logic [7:0]  MWR_TAG          = 8'h01;
  localparam logic [3:0]  BYTE_EN_ALL      = 4'hF;    // first and last DW BE

endpackage

`default_nettype wire

// File: hdl/audio_dma_top.sv
/* Audio uplink endpoint: host config writes arm it, samples go out as MWr TLPs.
   TLP_DW must be a multiple of 4, at most 1023, and TLP_DW/4 must fit in the FIFO.
   The command input is never stalled. */
`default_nettype none

module audio_dma_top #(
  parameter int TLP_DW  = 16,
  parameter int FIFO_AW = 6
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  audio_dma_pkg::in_beat_t  cmd,
  output audio_dma_pkg::out_beat_t tlp,
  output logic                     tlp_valid,
  input  logic                     tlp_ready,
  input  audio_dma_pkg::sample_t   sample,
  input  logic                     de_in,
  input  audio_dma_pkg::bus_num_t  bus_num,
  input  audio_dma_pkg::dev_num_t  dev_num
);
  import audio_dma_pkg::*;

  dma_addr_t        addr0;
  dma_addr_t        tlp_addr;
  beat_t            rd_data;
  logic [FIFO_AW:0] level;
  logic             armed;
  logic             clear;
  logic             rd_en;
  logic             final_beat;
  logic             start;
  logic             step;

  cmd_decoder u_cmd_decoder (
    .clk   (clk),
    .rstn  (rstn),
    .cmd   (cmd),
    .addr0 (addr0),
    .armed (armed),
    .clear (clear)
  );

  sample_fifo #(.FIFO_AW(FIFO_AW)) u_sample_fifo (
    .clk     (clk),
    .rstn    (rstn),
    .clear   (clear),
    .wr_en   (de_in && armed),  // samples before arming are dropped
    .sample  (sample),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .level   (level)
  );

  tlp_beat_counter #(.TLP_DW(TLP_DW)) u_tlp_beat_counter (
    .clk        (clk),
    .rstn       (rstn),
    .clear      (clear),
    .start      (start),
    .step       (step),
    .base       (addr0),
    .final_beat (final_beat),
    .tlp_addr   (tlp_addr)
  );

  mwr_fsm #(.TLP_DW(TLP_DW), .FIFO_AW(FIFO_AW)) u_mwr_fsm (
    .clk        (clk),
    .rstn       (rstn),
    .clear      (clear),
    .armed      (armed),
    .level      (level),
    .rd_data    (rd_data),
    .rd_en      (rd_en),
    .tlp_addr   (tlp_addr),
    .final_beat (final_beat),
    .start      (start),
    .step       (step),
    .bus_num    (bus_num),
    .dev_num    (dev_num),
    .tlp        (tlp),
    .tlp_valid  (tlp_valid),
    .tlp_ready  (tlp_ready)
  );

endmodule

`default_nettype wire

// File: hdl/cmd_decoder.sv
/* Decodes 1-DW memory writes from the host into DMA configuration.
   The header beat is the first valid beat after an idle cycle, the payload beat follows it.
   A write takes effect two cycles after its payload beat. */
`default_nettype none

module cmd_decoder (
  input  logic                     clk,
  input  logic                     rstn,
  input  audio_dma_pkg::in_beat_t  cmd,
  output audio_dma_pkg::dma_addr_t addr0,
  output logic                     armed,
  output logic                     clear
);
  import audio_dma_pkg::*;

  localparam int NUM_SLOTS = 4;
  localparam int ROT_W     = $clog2(NUM_SLOTS);

  logic             valid_q;
  logic             valid_q2;
  beat_t            data_q;
  logic             hdr_hit;
  logic             is_wr1;
  logic             addr_wr_q;
  logic             clr_q;
  dma_addr_t        payload;
  dma_addr_t        slot_q [NUM_SLOTS];
  logic [ROT_W-1:0] rot_q;

  assign hdr_hit = valid_q && !valid_q2;  // rising edge of valid
  assign is_wr1  = hdr_hit && (data_q[31:24] == MWR32_FMT_TYPE) && (data_q[9:0] == 10'd1);
  // host dword arrives byte-swapped
  assign payload = {data_q[7:0], data_q[15:8], data_q[23:16], data_q[31:24]};
  assign addr0   = slot_q[0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q  <= 1'b0;
      valid_q2 <= 1'b0;
    end else begin
      valid_q  <= cmd.valid;
      valid_q2 <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= cmd.data;
  end

  // flags line up with the payload beat sitting in data_q
  always_ff @(posedge clk) begin
    if (!rstn) begin
      addr_wr_q <= 1'b0;
      clr_q     <= 1'b0;
    end else begin
      addr_wr_q <= is_wr1 && (data_q[75:64] == CMD_ADDR_OFFSET);
      clr_q     <= is_wr1 && (data_q[75:64] == CMD_CLEAR_OFFSET);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || clr_q) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        slot_q[i] <= '0;
      end
      rot_q <= '0;
    end else if (addr_wr_q) begin
      slot_q[rot_q] <= payload;  // slots filled in rotation
      rot_q         <= rot_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      clear <= 1'b0;
    end else begin
      clear <= clr_q;  // same cycle as the slot wipe
    end
  end

  always_comb begin
    armed = 1'b1;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (slot_q[i] == '0) begin
        armed = 1'b0;  // any empty slot holds off capture
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/mwr_fsm.sv
/* Sends one 3DW MWr TLP per TLP_DW/4 stored beats, header first.
   The next FIFO word is prefetched so data beats leave back to back. */
`default_nettype none

module mwr_fsm #(
  parameter int TLP_DW  = 16,
  parameter int FIFO_AW = 6
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      clear,
  input  logic                      armed,
  input  logic [FIFO_AW:0]          level,
  input  audio_dma_pkg::beat_t      rd_data,
  output logic                      rd_en,
  input  audio_dma_pkg::dma_addr_t  tlp_addr,
  input  logic                      final_beat,
  output logic                      start,
  output logic                      step,
  input  audio_dma_pkg::bus_num_t   bus_num,
  input  audio_dma_pkg::dev_num_t   dev_num,
  output audio_dma_pkg::out_beat_t  tlp,
  output logic                      tlp_valid,
  input  logic                      tlp_ready
);
  import audio_dma_pkg::*;

  localparam int NBEAT = TLP_DW / 4;

  typedef enum logic [1:0] {S_IDLE, S_HDR, S_DATA} state_t;

  state_t state_q;
  beat_t  hdr;
  beat_t  data_q;
  logic   last_q;
  logic   accept;
  logic   go;

  assign accept = tlp_valid && tlp_ready;
  assign go     = (state_q == S_IDLE) && armed && (level >= (FIFO_AW + 1)'(NBEAT));
  assign start  = (state_q == S_HDR) && accept;
  assign step   = (state_q == S_DATA) && accept;
  // one pop ahead of each load, none once the last word is fetched
  assign rd_en  = go || (start && (NBEAT > 1)) || (step && !final_beat && !last_q);
  assign tlp    = '{data: data_q, last: last_q};

  always_comb begin
    hdr          = '0;
    hdr[9:0]     = 10'(TLP_DW);
    hdr[31:24]   = MWR32_FMT_TYPE;
    hdr[35:32]   = BYTE_EN_ALL;
    hdr[39:36]   = BYTE_EN_ALL;
    hdr[47:40]   = MWR_TAG;
    hdr[63:48]   = {bus_num, dev_num, 3'b000};  // function 0
    hdr[95:64]   = tlp_addr;
  end

  always_ff @(posedge clk) begin
    if (!rstn || clear) begin
      state_q   <= S_IDLE;
      tlp_valid <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: if (go) begin
          state_q   <= S_HDR;
          tlp_valid <= 1'b1;
        end
        S_HDR: if (accept) begin
          state_q <= S_DATA;
          last_q  <= (NBEAT == 1);
        end
        S_DATA: if (accept) begin
          if (last_q) begin
            state_q   <= S_IDLE;
            tlp_valid <= 1'b0;
            last_q    <= 1'b0;
          end else begin
            last_q <= final_beat;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      data_q <= hdr;
    end else if (start || (step && !last_q)) begin
      data_q <= rd_data;  // prefetched word
    end
  end

endmodule

`default_nettype wire

// File: hdl/sample_fifo.sv
/* Packs 16-bit samples eight to a beat and buffers the beats.
   A completed beat is lost when the FIFO is full. rd_en must only be
   raised while level is nonzero; rd_data follows one cycle later. */
`default_nettype none

module sample_fifo #(
  parameter int FIFO_AW = 6
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   clear,
  input  logic                   wr_en,
  input  audio_dma_pkg::sample_t sample,
  input  logic                   rd_en,
  output audio_dma_pkg::beat_t   rd_data,
  output logic [FIFO_AW:0]       level
);
  import audio_dma_pkg::*;

  localparam int DEPTH = 2 ** FIFO_AW;
  localparam int IDX_W = $clog2(SAMPLES_PER_BEAT);

  beat_t              mem_q [DEPTH];
  beat_t              pack_q;
  beat_t              full_beat;
  logic [IDX_W-1:0]   idx_q;
  logic [FIFO_AW-1:0] wptr_q;
  logic [FIFO_AW-1:0] rptr_q;
  logic               full;
  logic               push;
  logic               pop;

  assign full = (level == (FIFO_AW + 1)'(DEPTH));
  assign push = wr_en && (idx_q == IDX_W'(SAMPLES_PER_BEAT - 1)) && !full;
  assign pop  = rd_en && (level != '0);

  // eighth sample goes straight into the top lane
  always_comb begin
    full_beat = pack_q;
    full_beat[SAMPLE_W*(SAMPLES_PER_BEAT-1) +: SAMPLE_W] = sample;
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      pack_q[SAMPLE_W*idx_q +: SAMPLE_W] <= sample;  // first sample lowest
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || clear) begin
      idx_q <= '0;
    end else if (wr_en) begin
      idx_q <= idx_q + 1'b1;  // wraps after eight
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wptr_q] <= full_beat;
    end
    if (pop) begin
      rd_data <= mem_q[rptr_q];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || clear) begin
      wptr_q <= '0;
      rptr_q <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/tlp_beat_counter.sv
/* Tracks progress through one TLP and the running write address.
   final_beat flags that the beat waiting at the FIFO output is the packet's last. */
`default_nettype none

module tlp_beat_counter #(
  parameter int TLP_DW = 16
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     clear,
  input  logic                     start,
  input  logic                     step,
  input  audio_dma_pkg::dma_addr_t base,
  output logic                     final_beat,
  output audio_dma_pkg::dma_addr_t tlp_addr
);
  import audio_dma_pkg::*;

  localparam int NBEAT = TLP_DW / 4;
  localparam int CNT_W = $clog2(NBEAT + 1);

  logic [CNT_W-1:0] cnt_q;     // beats loaded for output so far
  dma_addr_t        offset_q;

  always_ff @(posedge clk) begin
    if (!rstn || clear) begin
      cnt_q    <= '0;
      offset_q <= '0;
    end else if (start) begin
      cnt_q <= CNT_W'(1);  // first data beat goes out with the header accept
    end else if (step) begin
      if (cnt_q == CNT_W'(NBEAT)) begin
        cnt_q    <= '0;
        offset_q <= offset_q + dma_addr_t'(TLP_DW * 4);  // next packet slot
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign final_beat = (cnt_q == CNT_W'(NBEAT - 1));
  assign tlp_addr   = base + offset_q;

endmodule

`default_nettype wire

// File: src.f
hdl/audio_dma_pkg.sv
hdl/cmd_decoder.sv
hdl/sample_fifo.sv
hdl/tlp_beat_counter.sv
hdl/mwr_fsm.sv
hdl/audio_dma_top.sv
tests/audio_dma_assert.sv
tests/tb_audio_dma.sv

// File: tests/audio_dma_assert.sv
/* Output stream protocol checks, bound into audio_dma_top.
   A clear may drop a stalled beat, so the hold check skips that cycle. */
`default_nettype none

module audio_dma_assert (
  input logic                     clk,
  input logic                     rstn,
  input logic                     clear,
  input audio_dma_pkg::out_beat_t tlp,
  input logic                     tlp_valid,
  input logic                     tlp_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;  // failed assertions so far

  // synchronous reset, so valid is low one cycle in
  valid_low_in_reset: assert property (@(posedge clk) !rstn |=> !tlp_valid)
    else begin
      fail_cnt++;
      $error("tlp_valid high while in reset");
    end

  last_needs_valid: assert property (@(posedge clk) disable iff (!rstn)
    tlp.last |-> tlp_valid)
    else begin
      fail_cnt++;
      $error("tlp.last seen without tlp_valid");
    end

  hold_under_stall: assert property (@(posedge clk) disable iff (!rstn)
    tlp_valid && !tlp_ready && !clear |=> tlp_valid && $stable(tlp))
    else begin
      fail_cnt++;
      $error("output beat changed while stalled");
    end

endmodule

bind audio_dma_top audio_dma_assert u_stream_assert (
  .clk       (clk),
  .rstn      (rstn),
  .clear     (clear),
  .tlp       (tlp),
  .tlp_valid (tlp_valid),
  .tlp_ready (tlp_ready)
);

`default_nettype wire

// File: tests/tb_audio_dma.sv
/* Testbench for audio_dma_top with TLP_DW 16 and a 64-beat FIFO.
   Pushes stay far below FIFO depth, so no completed beat is ever dropped. */
`default_nettype none

module tb_audio_dma;
  timeunit 1ns;
  timeprecision 1ps;
  import audio_dma_pkg::*;

  localparam int TLP_DW    = 16;
  localparam int FIFO_AW   = 6;
  localparam int NBEAT     = TLP_DW / 4;
  localparam int NUM_STEPS = 15;
  localparam logic [1:0] K_ADDR  = 2'd0;
  localparam logic [1:0] K_CLEAR = 2'd1;
  localparam logic [1:0] K_PUSH  = 2'd2;

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] value;  // raw payload dword or beat count
    logic [7:0]  pkts;   // packets this step should produce
    logic        bp;     // random tready during the step
  } step_t;

  logic      clk;
  logic      rstn;
  in_beat_t  cmd;
  out_beat_t tlp;
  logic      tlp_valid;
  logic      tlp_ready = 1'b0;
  sample_t   sample;
  logic      de_in;
  bus_num_t  bus_num;
  dev_num_t  dev_num;

  step_t     steps [NUM_STEPS];
  out_beat_t exp_q [$];
  bit        hdr_q [$];
  beat_t     pend_q [$];  // beats captured but not yet in a packet
  integer    seed;
  logic      bp_on;
  int        nslots;
  int        pkt_idx;
  int        sample_cnt;
  dma_addr_t base;

  audio_dma_top #(.TLP_DW(TLP_DW), .FIFO_AW(FIFO_AW)) dut (
    .clk       (clk),
    .rstn      (rstn),
    .cmd       (cmd),
    .tlp       (tlp),
    .tlp_valid (tlp_valid),
    .tlp_ready (tlp_ready),
    .sample    (sample),
    .de_in     (de_in),
    .bus_num   (bus_num),
    .dev_num   (dev_num)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_beat(input string name, input out_beat_t exp, input out_beat_t got);
    if (got.data !== exp.data) begin
      $display("FAILED %s.data expected %h got %h", name, exp.data, got.data);
      abort_run();
    end else if (got.last !== exp.last) begin
      $display("FAILED %s.last expected %h got %h", name, exp.last, got.last);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input dma_addr_t exp, input dma_addr_t got);
    if (got !== exp) begin
      $display("FAILED %s expected %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  function automatic dma_addr_t byte_reverse(input logic [31:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  function automatic sample_t sample_value(input int n);
    return 16'(n * 1237 + 16'h02b1);
  endfunction

  function automatic beat_t make_header(input dma_addr_t addr);
    beat_t h;
    h = '0;
    h[9:0]   = 10'(TLP_DW);
    h[31:29] = 3'b010;  // 3DW with data, type 0
    h[35:32] = 4'hF;
    h[39:36] = 4'hF;
    h[47:40] = 8'h01;   // tag
    h[63:56] = bus_num;
    h[55:51] = dev_num; // function 0 in 50:48
    h[95:64] = addr;
    return h;
  endfunction

  task automatic load_table();
    steps[0]  = '{K_ADDR,  32'h00001080, 8'd0, 1'b0};
    steps[1]  = '{K_ADDR,  32'h00002080, 8'd0, 1'b0};
    steps[2]  = '{K_ADDR,  32'h00003080, 8'd0, 1'b0};
    steps[3]  = '{K_PUSH,  32'd2,        8'd0, 1'b0};  // not armed yet
    steps[4]  = '{K_ADDR,  32'h00004080, 8'd0, 1'b0};
    steps[5]  = '{K_PUSH,  32'd4,        8'd1, 1'b0};
    steps[6]  = '{K_PUSH,  32'd10,       8'd2, 1'b1};
    steps[7]  = '{K_PUSH,  32'd5,        8'd1, 1'b1};  // leaves 3 beats in the FIFO
    steps[8]  = '{K_CLEAR, 32'd0,        8'd0, 1'b0};
    steps[9]  = '{K_PUSH,  32'd4,        8'd0, 1'b1};
    steps[10] = '{K_ADDR,  32'h0000a0c0, 8'd0, 1'b0};
    steps[11] = '{K_ADDR,  32'h0000b0c0, 8'd0, 1'b0};
    steps[12] = '{K_ADDR,  32'h0000c0c0, 8'd0, 1'b0};
    steps[13] = '{K_ADDR,  32'h0000d0c0, 8'd0, 1'b0};
    steps[14] = '{K_PUSH,  32'd8,        8'd2, 1'b1};
  endtask

  // header beat then payload beat, then idle until the write has landed
  task automatic send_cmd(input logic [11:0] offset, input logic [31:0] dword);
    in_beat_t b;
    b = '0;
    b.valid         = 1'b1;
    b.data[31:24]   = MWR32_FMT_TYPE;
    b.data[9:0]     = 10'd1;
    b.data[75:64]   = offset;
    @(posedge clk);
    cmd <= b;
    b.data       = '0;
    b.data[31:0] = dword;
    b.last       = 1'b1;
    @(posedge clk);
    cmd <= b;
    @(posedge clk);
    cmd <= '0;
    repeat (4) @(posedge clk);
  endtask

  task automatic queue_packet();
    out_beat_t e;
    int        k;
    e.data = make_header(base + dma_addr_t'(pkt_idx * TLP_DW * 4));
    e.last = 1'b0;
    exp_q.push_back(e);
    hdr_q.push_back(1'b1);
    for (k = 0; k < NBEAT; k++) begin
      e.data = pend_q.pop_front();
      e.last = (k == NBEAT - 1);
      exp_q.push_back(e);
      hdr_q.push_back(1'b0);
    end
    pkt_idx++;
  endtask

  // model first, so expected beats exist before the DUT can send them
  task automatic push_beats(input int count, output int made);
    sample_t s [$];
    beat_t   b;
    int      k;
    int      j;
    made = 0;
    for (k = 0; k < count; k++) begin
      b = '0;
      for (j = 0; j < SAMPLES_PER_BEAT; j++) begin
        b[16*j +: 16] = sample_value(sample_cnt);
        s.push_back(sample_value(sample_cnt));
        sample_cnt++;
      end
      if (nslots == 4) begin
        pend_q.push_back(b);
      end
    end
    while (pend_q.size() >= NBEAT) begin
      queue_packet();
      made++;
    end
    for (k = 0; k < s.size(); k++) begin
      @(posedge clk);
      sample <= s[k];
      de_in  <= 1'b1;
    end
    @(posedge clk);
    de_in <= 1'b0;
  endtask

  always @(posedge clk) begin
    integer rnd;
    rnd = $random(seed);
    tlp_ready <= bp_on ? rnd[0] : 1'b1;
  end

  // sampled mid-cycle, where the handshake of the next edge is settled
  always @(negedge clk) begin
    out_beat_t e;
    bit        hdr;
    if (rstn && tlp_valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: tlp_valid high while no beat is expected");
        abort_run();
      end else if (tlp_ready) begin
        e   = exp_q.pop_front();
        hdr = hdr_q.pop_front();
        if (hdr) begin
          check_addr("tlp.data[95:64]", e.data[95:64], tlp.data[95:64]);
        end
        check_beat("tlp", e, tlp);
      end
    end
  end

  // a failed stream protocol assertion ends the run as well
  initial begin
    wait (dut.u_stream_assert.fail_cnt != 0);
    $display("ERROR: a protocol assertion on the TLP output stream failed");
    abort_run();
  end

  initial begin
    int total;
    int k;
    int limit;
    @(posedge rstn);
    total = 0;
    for (k = 0; k < NUM_STEPS; k++) begin
      if (steps[k].kind == K_PUSH) begin
        total += steps[k].value;
      end
    end
    limit = total * SAMPLES_PER_BEAT * 4 + NUM_STEPS * 64;
    repeat (limit) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles", limit);
    abort_run();
  end

  initial begin
    int i;
    int made;
    seed       = 54866;
    rstn       = 1'b0;
    cmd        = '0;
    sample     = '0;
    de_in      = 1'b0;
    bus_num    = 8'h3a;
    dev_num    = 5'h11;
    bp_on      = 1'b0;
    nslots     = 0;
    pkt_idx    = 0;
    sample_cnt = 0;
    base       = '0;
    load_table();
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    repeat (2) @(posedge clk);
    for (i = 0; i < NUM_STEPS; i++) begin
      bp_on <= steps[i].bp;
      made = 0;
      case (steps[i].kind)
        K_ADDR: begin
          nslots++;
          if (nslots == 1) begin
            base = byte_reverse(steps[i].value);
          end
          send_cmd(CMD_ADDR_OFFSET, steps[i].value);
        end
        K_CLEAR: begin
          nslots  = 0;
          pkt_idx = 0;
          pend_q.delete();  // FIFO contents are flushed
          send_cmd(CMD_CLEAR_OFFSET, 32'd0);
        end
        default: push_beats(steps[i].value, made);
      endcase
      if (made != steps[i].pkts) begin
        $display("ERROR: step %0d expects %0d packets, model built %0d", i, steps[i].pkts, made);
        abort_run();
      end
      if (dut.armed !== ((nslots == 4) ? 1'b1 : 1'b0)) begin
        $display("FAILED armed expected %h got %h after step %0d", (nslots == 4), dut.armed, i);
        abort_run();
      end
      while (exp_q.size() != 0) @(posedge clk);
      repeat (16) @(posedge clk);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
